// ==== files.f ====
src/noclsu_pkg.sv
src/noclsu_ctrl.sv
src/noclsu_flit_tx.sv
src/noclsu_resp_rx.sv
src/noclsu_tile.sv
sim/tb_clk_gen.sv
sim/noclsu_sva.sv
sim/noclsu_tb.sv

// ==== sim/noclsu_tb.sv ====
/*
 * noclsu tile testbench
 * random ic/dc masters, memory tile model with delayed responses,
 * reference flit builder and a checker on every flit and ack
 */
module noclsu_tb;
   import noclsu_pkg::*;

   localparam int          PGAS_BASE = 3;
   localparam int          N_IC      = 24;
   localparam int          N_DC      = 24;
   localparam int          TIMEOUT   = 200 * (N_IC + N_DC) + 100;
   localparam logic [31:0] FILL      = 32'h5a5a_a5a5;  // unwritten word pattern

   typedef struct {
      int          due;
      flit_t       hdr;
      logic [31:0] dat;
   } resp_t;

   logic        clk;
   logic        rst;
   wb_req_t     ic_req;
   wb_req_t     dc_req;
   logic [31:0] ic_dat;
   logic [31:0] dc_dat;
   logic        ic_ack;
   logic        dc_ack;
   flit_t       out_flit;
   logic        out_valid;
   logic        out_ready;
   flit_t       in_flit;
   logic        in_valid;
   logic        in_ready;

   flit_t       exp_q [2][$];    // expected flits, port 0 is ic
   bit          active [2];
   bit          exp_wr [2];
   logic [31:0] exp_dat [2];
   int          outst [2];       // reads in flight
   logic [31:0] ref_mem [logic [31:0]];
   logic [31:0] mem [logic [31:0]];  // memory tile contents
   resp_t       resp_q [$];
   int          cycles;
   int          cur_port;
   noc_hdr_t    pkt_hdr;
   logic [31:0] pkt_adr;
   bit          hdr_seen;

   tb_clk_gen #(.PERIOD(4)) u_clk (.clk_o(clk));

   noclsu_tile #(.PGAS_BASE(PGAS_BASE)) u_dut (
      .clk             (clk),
      .rst             (rst),
      .ic_req_i        (ic_req),
      .ic_dat_o        (ic_dat),
      .ic_ack_o        (ic_ack),
      .dc_req_i        (dc_req),
      .dc_dat_o        (dc_dat),
      .dc_ack_o        (dc_ack),
      .noc_out_flit_o  (out_flit),
      .noc_out_valid_o (out_valid),
      .noc_out_ready_i (out_ready),
      .noc_in_flit_i   (in_flit),
      .noc_in_valid_i  (in_valid),
      .noc_in_ready_o  (in_ready)
   );

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_eq(input logic [63:0] act, input logic [63:0] exp, input string what);
      if (act !== exp) begin
         $display("ERR %0t: %s, got %0h expected %0h", $time, what, act, exp);
         $display("TEST FAIL");
         $fatal(1, "run stopped");
      end
   endtask

   function automatic logic [31:0] pgas_addr(input logic [31:0] a);
      return {15'(PGAS_BASE), a[16:0]};  // top 15 bits from the partition base
   endfunction

   // header: dest 2, class, src 0, msgtype, rtype, size, bsel, reserved
   function automatic int ref_flits(input wb_req_t r, input int port, output flit_t f [3]);
      msgtype_e    mt;
      logic [31:0] hdr;
      mt   = r.we ? MSG_WRITEREQ : MSG_READREQ;
      hdr  = {5'd2, LSU_CLASS, 5'd0, mt, port[0], (r.cti == CTI_BURST),
              (r.we ? r.sel : 4'h0), 11'h0};
      f[0] = {1'b0, 1'b1, hdr};
      f[1] = {~r.we, 1'b0, pgas_addr(r.adr)};  // last only on reads
      f[2] = {1'b1, 1'b0, r.dat};
      return r.we ? 3 : 2;
   endfunction

   task automatic run_access(input int port, input wb_req_t r);
      flit_t       f [3];
      int          n;
      logic [31:0] xa;
      n  = ref_flits(r, port, f);
      xa = pgas_addr(r.adr);
      for (int i = 0; i < n; i++) exp_q[port].push_back(f[i]);
      exp_wr[port]  = r.we;
      exp_dat[port] = ref_mem.exists(xa) ? ref_mem[xa] : xa ^ FILL;
      if (r.we) ref_mem[xa] = r.dat;
      active[port] = 1'b1;
      if (port == 0) ic_req = r;
      else           dc_req = r;
      while (active[port]) @(negedge clk);  // held until acked
      if (port == 0) ic_req = '0;
      else           dc_req = '0;
   endtask

   task automatic run_master(input int port, input int n);
      wb_req_t r;
      repeat (n) begin
         r     = '0;
         r.adr = $urandom;
         r.dat = $urandom;
         r.sel = 4'($urandom);
         r.cyc = 1'b1;
         r.stb = 1'b1;
         r.cti = ($urandom % 2) ? CTI_BURST : 3'($urandom);
         if (port == 0) begin
            r.adr[16] = 1'b0;  // ic region apart from dc
         end else begin
            r.adr[16:4] = 13'h1000;  // four dc words so reads hit writes
            r.adr[1:0]  = 2'b00;
            r.we        = 1'($urandom);
         end
         run_access(port, r);
         repeat ($urandom % 3) @(negedge clk);
      end
   endtask

   task automatic check_out_flit(input flit_t f);
      noc_hdr_t    h;
      flit_t       e;
      flit_t       rh;
      logic [31:0] d;
      h = noc_hdr_t'(f.payload);
      if (f.first) begin
         cur_port = int'(h.rtype);
         pkt_hdr  = h;
         if (!hdr_seen) check_eq(h.rtype, RTYPE_I, "ic header not sent first");
         hdr_seen = 1'b1;
         if (h.msgtype == MSG_READREQ) begin
            check_eq(outst[cur_port], 0, "read sent while port busy");
            outst[cur_port]++;
         end
      end
      if (exp_q[cur_port].size() == 0) stop_run("flit sent with no request pending");
      e = exp_q[cur_port].pop_front();
      check_eq(f, e, "output flit");
      if (!f.first && !f.last) pkt_adr = f.payload;
      if (f.last && pkt_hdr.msgtype == MSG_WRITEREQ) begin
         mem[pkt_adr] = f.payload;
      end else if (f.last) begin
         pkt_hdr.msgtype = MSG_READRESP;  // same target
         rh = {1'b0, 1'b1, pkt_hdr};
         d  = mem.exists(f.payload) ? mem[f.payload] : f.payload ^ FILL;
         resp_q.push_back('{due: cycles + ((cur_port == 0) ? 3 + int'($urandom % 20) :
                                           1 + int'($urandom % 6)), hdr: rh, dat: d});
      end
   endtask

   task automatic check_ack(input int port, input logic [31:0] dat);
      check_eq(active[port], 1'b1, "ack with no access pending");
      if (exp_wr[port]) begin
         check_eq(out_valid & out_ready, 1'b1, "write ack outside data handshake");
         check_eq(exp_q[port].size(), 0, "write ack before data flit");
      end else begin
         check_eq(outst[port], 1, "read ack with no read in flight");
         check_eq(dat, exp_dat[port], "read data");
         outst[port]--;
      end
      active[port] = 1'b0;
   endtask

   task automatic send_flit(input flit_t f);
      in_flit  = f;
      in_valid = 1'b1;
      do begin
         @(posedge clk);
      end while (!in_ready);
      @(negedge clk);
   endtask

   // compare process
   always @(posedge clk) begin
      if (!rst) begin
         if (u_dut.u_sva.err_cnt != 0) stop_run("protocol assertion failed");
         check_eq(in_ready & out_valid, 1'b0, "input ready while a request flit is offered");
         if (out_valid && out_ready) check_out_flit(out_flit);
         if (ic_ack) check_ack(0, ic_dat);
         if (dc_ack) check_ack(1, dc_dat);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > TIMEOUT) stop_run("timeout, accesses did not complete in time");
   end

   always @(negedge clk) begin
      if (!rst) out_ready = ($urandom % 4) != 0;  // random back-pressure
   end

   // memory tile responses, earliest due first
   initial begin : resp_driver
      resp_t r;
      int    k;
      forever begin
         @(negedge clk);
         k = -1;
         foreach (resp_q[i]) begin
            if (resp_q[i].due <= cycles && (k < 0 || resp_q[i].due < resp_q[k].due)) k = i;
         end
         if (k >= 0) begin
            r = resp_q[k];
            resp_q.delete(k);
            send_flit(r.hdr);
            send_flit({1'b1, 1'b0, r.dat});
            in_valid = 1'b0;
         end
      end
   end

   initial begin
      void'($urandom(32'hf08d_bccc));
      cycles    = 0;
      hdr_seen  = 1'b0;
      rst       = 1'b1;
      ic_req    = '0;
      dc_req    = '0;
      out_ready = 1'b0;
      in_flit   = '0;
      in_valid  = 1'b0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      fork
         run_master(0, N_IC);
         run_master(1, N_DC);
      join
      repeat (10) @(negedge clk);
      check_eq(exp_q[0].size() + exp_q[1].size(), 0, "expected flits never sent");
      check_eq(resp_q.size(), 0, "responses never returned");
      if (u_dut.u_sva.err_cnt == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("protocol assertions failed during the run");
         $display("TEST FAIL");
         $fatal(1, "run stopped");
      end
   end

endmodule

// ==== sim/noclsu_sva.sv ====
/*
 * noclsu protocol assertions
 * flit hold under back-pressure, ack timing and output state after reset
 */
module noclsu_sva (
   input logic              clk,
   input logic              rst,
   input noclsu_pkg::flit_t out_flit_i,
   input logic              out_valid_i,
   input logic              out_ready_i,
   input logic              in_valid_i,
   input logic              in_ready_i,
   input logic              ic_ack_i,
   input logic              dc_ack_i
);
   int err_cnt = 0;  // failed assertions so far

   // stalled flit must not move
   a_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
      else begin
         err_cnt++;
         $error("output flit or valid changed while ready was low");
      end

   a_ack: assert property (@(posedge clk) disable iff (rst)
      (ic_ack_i || dc_ack_i) |-> (in_valid_i && in_ready_i) || (out_valid_i && out_ready_i))
      else begin
         err_cnt++;
         $error("cache ack outside a flit handshake");
      end

   a_rst: assert property (@(posedge clk) rst |=> !out_valid_i)
      else begin
         err_cnt++;
         $error("output valid high right after reset");
      end

endmodule

bind noclsu_tile noclsu_sva u_sva (
   .clk         (clk),
   .rst         (rst),
   .out_flit_i  (noc_out_flit_o),
   .out_valid_i (noc_out_valid_o),
   .out_ready_i (noc_out_ready_i),
   .in_valid_i  (noc_in_valid_i),
   .in_ready_i  (noc_in_ready_o),
   .ic_ack_i    (ic_ack_o),
   .dc_ack_i    (dc_ack_o)
);

// ==== sim/tb_clk_gen.sv ====
/*
 * testbench clock source
 */
module tb_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk_o
);
   initial clk_o = 1'b0;

   always #(PERIOD / 2) clk_o = ~clk_o;  // free running

endmodule

// ==== src/noclsu_tile.sv ====
/*
 * noclsu tile top
 * load/store unit between ic/dc Wishbone masters and the NoC
 */
module noclsu_tile #(
   parameter int TILE_ID     = 0,
   parameter int MEM_ID      = 2,
   parameter bit PGAS_ENABLE = 1'b1,
   parameter int PGAS_ADDR_W = 15,
   parameter int PGAS_BASE   = 0
) (
   input  logic                clk,
   input  logic                rst,
   // cache ports
   input  noclsu_pkg::wb_req_t ic_req_i,
   output logic [31:0]         ic_dat_o,
   output logic                ic_ack_o,
   input  noclsu_pkg::wb_req_t dc_req_i,
   output logic [31:0]         dc_dat_o,
   output logic                dc_ack_o,
   // NoC
   output noclsu_pkg::flit_t   noc_out_flit_o,
   output logic                noc_out_valid_o,
   input  logic                noc_out_ready_i,
   input  noclsu_pkg::flit_t   noc_in_flit_i,
   input  logic                noc_in_valid_i,
   output logic                noc_in_ready_o
);
   import noclsu_pkg::*;

   flit_sel_e flit_sel;
   logic      noc_out_valid;
   flit_t     tx_flit;
   logic      hdr_is_resp;
   logic      resp_is_ic;
   logic      hdr_take;
   logic      deliver;
   logic      wr_done;

   noclsu_ctrl u_ctrl (
      .clk             (clk),
      .rst             (rst),
      .ic_req_i        (ic_req_i),
      .dc_req_i        (dc_req_i),
      .noc_out_ready_i (noc_out_ready_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .hdr_is_resp_i   (hdr_is_resp),
      .resp_is_ic_i    (resp_is_ic),
      .flit_sel_o      (flit_sel),
      .noc_out_valid_o (noc_out_valid),
      .noc_in_ready_o  (noc_in_ready_o),
      .hdr_take_o      (hdr_take),
      .deliver_o       (deliver),
      .wr_done_o       (wr_done)
   );

   noclsu_flit_tx #(
      .TILE_ID     (TILE_ID),
      .MEM_ID      (MEM_ID),
      .PGAS_ENABLE (PGAS_ENABLE),
      .PGAS_ADDR_W (PGAS_ADDR_W),
      .PGAS_BASE   (PGAS_BASE)
   ) u_tx (
      .ic_req_i   (ic_req_i),
      .dc_req_i   (dc_req_i),
      .flit_sel_i (flit_sel),
      .flit_o     (tx_flit)
   );

   noclsu_resp_rx u_rx (
      .clk           (clk),
      .rst           (rst),
      .noc_in_flit_i (noc_in_flit_i),
      .hdr_take_i    (hdr_take),
      .deliver_i     (deliver),
      .wr_done_i     (wr_done),
      .hdr_is_resp_o (hdr_is_resp),
      .resp_is_ic_o  (resp_is_ic),
      .ic_dat_o      (ic_dat_o),
      .ic_ack_o      (ic_ack_o),
      .dc_dat_o      (dc_dat_o),
      .dc_ack_o      (dc_ack_o)
   );

   assign noc_out_flit_o  = tx_flit;
   assign noc_out_valid_o = noc_out_valid;

endmodule

// ==== src/noclsu_resp_rx.sv ====
/*
 * noclsu receive datapath
 * decodes read-response headers, holds the response target
 * and steers ack and data to the ic or dc port
 */
module noclsu_resp_rx (
   input  logic              clk,
   input  logic              rst,
   input  noclsu_pkg::flit_t noc_in_flit_i,
   input  logic              hdr_take_i,
   input  logic              deliver_i,
   input  logic              wr_done_i,
   output logic              hdr_is_resp_o,
   output logic              resp_is_ic_o,
   output logic [31:0]       ic_dat_o,
   output logic              ic_ack_o,
   output logic [31:0]       dc_dat_o,
   output logic              dc_ack_o
);
   import noclsu_pkg::*;

   noc_hdr_t hdr;
   logic     resp_is_ic;
   logic     dc_rd_ack;

   assign hdr = noc_hdr_t'(noc_in_flit_i.payload);

   // header flit carries first only
   assign hdr_is_resp_o = noc_in_flit_i.first & ~noc_in_flit_i.last &
                          (hdr.msgtype == MSG_READRESP);

   always_ff @(posedge clk) begin
      if (rst) begin
         resp_is_ic <= 1'b0;
      end else if (hdr_take_i) begin
         resp_is_ic <= (hdr.rtype == RTYPE_I);
      end
   end

   assign resp_is_ic_o = resp_is_ic;

   assign ic_ack_o  = deliver_i & resp_is_ic;
   assign dc_rd_ack = deliver_i & ~resp_is_ic;
   assign dc_ack_o  = dc_rd_ack | wr_done_i;  // write completion too

   assign ic_dat_o = ic_ack_o  ? noc_in_flit_i.payload : 32'h0;
   assign dc_dat_o = dc_rd_ack ? noc_in_flit_i.payload : 32'h0;

endmodule

// ==== src/noclsu_flit_tx.sv ====
/*
 * noclsu transmit datapath
 * forms header, address and data flits for the selected request,
 * with optional PGAS address translation
 */
module noclsu_flit_tx #(
   parameter int TILE_ID     = 0,
   parameter int MEM_ID      = 2,
   parameter bit PGAS_ENABLE = 1'b1,
   parameter int PGAS_ADDR_W = 15,
   parameter int PGAS_BASE   = 0
) (
   input  noclsu_pkg::wb_req_t   ic_req_i,
   input  noclsu_pkg::wb_req_t   dc_req_i,
   input  noclsu_pkg::flit_sel_e flit_sel_i,
   output noclsu_pkg::flit_t     flit_o
);
   import noclsu_pkg::*;

   // partition width kept inside the address
   localparam int XL_W = (PGAS_ADDR_W > ADDR_W) ? ADDR_W :
                         (PGAS_ADDR_W < 0)      ? 0      : PGAS_ADDR_W;
   localparam logic [31:0] PGAS_MASK = ~(32'hffff_ffff >> XL_W);  // upper XL_W bits
   localparam logic [31:0] PGAS_HI   = 32'(PGAS_BASE) << (ADDR_W - XL_W);

   noc_hdr_t    ic_hdr;
   noc_hdr_t    dc_hdr;
   logic [31:0] ic_adr;
   logic [31:0] dc_adr;

   function automatic logic [31:0] xlate(input logic [31:0] adr);
      if (PGAS_ENABLE) return (adr & ~PGAS_MASK) | (PGAS_HI & PGAS_MASK);
      return adr;
   endfunction

   function automatic noc_hdr_t mk_hdr(input msgtype_e mt, input rtype_e rt,
                                       input logic [2:0] cti, input logic [3:0] bsel);
      noc_hdr_t h;
      h         = '0;
      h.dest    = 5'(MEM_ID);
      h.cls     = LSU_CLASS;
      h.src     = 5'(TILE_ID);
      h.msgtype = mt;
      h.rtype   = rt;
      h.size    = (cti == CTI_BURST);
      h.bsel    = bsel;
      return h;
   endfunction

   assign ic_hdr = mk_hdr(MSG_READREQ, RTYPE_I, ic_req_i.cti, 4'h0);
   assign dc_hdr = mk_hdr(dc_req_i.we ? MSG_WRITEREQ : MSG_READREQ, RTYPE_D,
                          dc_req_i.cti, dc_req_i.we ? dc_req_i.sel : 4'h0);  // bsel on writes
   assign ic_adr = xlate(ic_req_i.adr);
   assign dc_adr = xlate(dc_req_i.adr);

   always_comb begin
      flit_o = '0;
      case (flit_sel_i)
         SEL_IC_HDR:       flit_o = '{last: 1'b0, first: 1'b1, payload: ic_hdr};
         SEL_IC_ADDR:      flit_o = '{last: 1'b1, first: 1'b0, payload: ic_adr};
         SEL_DC_RD_HDR,
         SEL_DC_WR_HDR:    flit_o = '{last: 1'b0, first: 1'b1, payload: dc_hdr};
         SEL_DC_ADDR_MID:  flit_o = '{last: 1'b0, first: 1'b0, payload: dc_adr};
         SEL_DC_ADDR_LAST: flit_o = '{last: 1'b1, first: 1'b0, payload: dc_adr};
         SEL_DC_DATA:      flit_o = '{last: 1'b1, first: 1'b0, payload: dc_req_i.dat};
         default:          flit_o = '0;
      endcase
   end

endmodule

// ==== src/noclsu_ctrl.sv ====
/*
 * noclsu control FSM
 * arbitrates response path, ic and dc; sequences request flits
 * and tracks one outstanding read per cache port
 */
module noclsu_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  noclsu_pkg::wb_req_t   ic_req_i,
   input  noclsu_pkg::wb_req_t   dc_req_i,
   input  logic                  noc_out_ready_i,
   input  logic                  noc_in_valid_i,
   input  logic                  hdr_is_resp_i,
   input  logic                  resp_is_ic_i,
   output noclsu_pkg::flit_sel_e flit_sel_o,
   output logic                  noc_out_valid_o,
   output logic                  noc_in_ready_o,
   output logic                  hdr_take_o,
   output logic                  deliver_o,
   output logic                  wr_done_o
);
   import noclsu_pkg::*;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_IC_HDR,
      ST_IC_ADDR,
      ST_DC_RD_HDR,
      ST_DC_RD_ADDR,
      ST_DC_WR_HDR,
      ST_DC_WR_ADDR,
      ST_DC_WR_DATA,
      ST_RESP
   } state_e;

   state_e state;
   state_e state_nxt;
   logic   ic_busy;       // ic read in flight
   logic   dc_busy;
   logic   ic_busy_nxt;
   logic   dc_busy_nxt;
   logic   ic_pend;
   logic   dc_pend;

   // a port may only start when no read of its own is outstanding
   assign ic_pend = ic_req_i.cyc & ic_req_i.stb & ~ic_busy;
   assign dc_pend = dc_req_i.cyc & dc_req_i.stb & ~dc_busy;

   always_comb begin
      state_nxt       = state;
      ic_busy_nxt     = ic_busy;
      dc_busy_nxt     = dc_busy;
      flit_sel_o      = SEL_IC_HDR;
      noc_out_valid_o = 1'b0;
      noc_in_ready_o  = 1'b0;
      hdr_take_o      = 1'b0;
      deliver_o       = 1'b0;
      wr_done_o       = 1'b0;

      case (state)
         ST_IDLE: begin
            noc_in_ready_o = 1'b1;  // stray flits are dropped here
            if (noc_in_valid_i && hdr_is_resp_i) begin
               hdr_take_o = 1'b1;
               state_nxt  = ST_RESP;
            end else if (ic_pend) begin
               state_nxt = ST_IC_HDR;
            end else if (dc_pend) begin
               state_nxt = dc_req_i.we ? ST_DC_WR_HDR : ST_DC_RD_HDR;
            end
         end
         ST_IC_HDR: begin
            flit_sel_o      = SEL_IC_HDR;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) state_nxt = ST_IC_ADDR;
         end
         ST_IC_ADDR: begin
            flit_sel_o      = SEL_IC_ADDR;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) begin
               ic_busy_nxt = 1'b1;
               state_nxt   = ST_IDLE;
            end
         end
         ST_DC_RD_HDR: begin
            flit_sel_o      = SEL_DC_RD_HDR;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) state_nxt = ST_DC_RD_ADDR;
         end
         ST_DC_RD_ADDR: begin
            flit_sel_o      = SEL_DC_ADDR_LAST;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) begin
               dc_busy_nxt = 1'b1;
               state_nxt   = ST_IDLE;
            end
         end
         ST_DC_WR_HDR: begin
            flit_sel_o      = SEL_DC_WR_HDR;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) state_nxt = ST_DC_WR_ADDR;
         end
         ST_DC_WR_ADDR: begin
            flit_sel_o      = SEL_DC_ADDR_MID;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) state_nxt = ST_DC_WR_DATA;
         end
         ST_DC_WR_DATA: begin
            flit_sel_o      = SEL_DC_DATA;
            noc_out_valid_o = 1'b1;
            if (noc_out_ready_i) begin
               wr_done_o = 1'b1;  // write acked on the data handshake
               state_nxt = ST_IDLE;
            end
         end
         ST_RESP: begin
            noc_in_ready_o = 1'b1;
            if (noc_in_valid_i) begin
               deliver_o = 1'b1;
               if (resp_is_ic_i) ic_busy_nxt = 1'b0;
               else              dc_busy_nxt = 1'b0;
               state_nxt = ST_IDLE;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         ic_busy <= 1'b0;
         dc_busy <= 1'b0;
      end else begin
         state   <= state_nxt;
         ic_busy <= ic_busy_nxt;
         dc_busy <= dc_busy_nxt;
      end
   end

endmodule

// ==== src/noclsu_pkg.sv ====
/*
 * noclsu shared types
 * flit framing, NoC header layout, message encodings and cache request bundle
 */
package noclsu_pkg;

   localparam int ADDR_W = 32;

   localparam logic [2:0] LSU_CLASS = 3'd2;    // traffic class of lsu packets
   localparam logic [2:0] CTI_BURST = 3'b010;  // incrementing burst

   typedef enum logic [1:0] {
      MSG_READREQ  = 2'd0,
      MSG_WRITEREQ = 2'd1,
      MSG_READRESP = 2'd2
   } msgtype_e;

   typedef enum logic {
      RTYPE_I = 1'b0,
      RTYPE_D = 1'b1
   } rtype_e;

   typedef struct packed {
      logic        last;
      logic        first;
      logic [31:0] payload;
   } flit_t;

   // header payload layout, msb first
   typedef struct packed {
      logic [4:0]  dest;
      logic [2:0]  cls;
      logic [4:0]  src;
      msgtype_e    msgtype;
      rtype_e      rtype;
      logic        size;     // 1 means burst
      logic [3:0]  bsel;
      logic [10:0] rsvd;
   } noc_hdr_t;

   typedef enum logic [2:0] {
      SEL_IC_HDR,
      SEL_IC_ADDR,
      SEL_DC_RD_HDR,
      SEL_DC_WR_HDR,
      SEL_DC_ADDR_MID,
      SEL_DC_ADDR_LAST,
      SEL_DC_DATA
   } flit_sel_e;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        cyc;
      logic        stb;
      logic        we;
      logic [2:0]  cti;
   } wb_req_t;

endpackage
